// File: design/stall_prof_pkg.sv
/* Stall reason encoding, reason bit vector and front-end command opcodes
   shared by the profiler blocks */
package stall_prof_pkg;

  // Encoding order is priority order, the lowest value wins
  typedef enum logic [3:0] {
    // Commit-time and redirect reasons
    e_mispredict   = 4'd0,
    e_exception    = 4'd1,
    e_itlb_miss    = 4'd2,
    e_dtlb_miss    = 4'd3,
    e_dc_miss      = 4'd4,
    // Fetch reasons
    e_ic_miss      = 4'd5,
    e_fe_cmd       = 4'd6,
    e_fe_cmd_fence = 4'd7,
    e_br_ovr       = 4'd8,
    // Issue hazards
    e_control_haz  = 4'd9,
    e_data_haz     = 4'd10,
    e_struct_haz   = 4'd11,
    e_long_haz     = 4'd12,
    // Nothing flagged for the lost cycle
    e_unknown      = 4'd13
  } stall_reason_e;

  // Real reasons only, e_unknown has no bit
  localparam int num_reasons_c = 13;

  // Bit i flags the reason encoded as i
  typedef logic [num_reasons_c-1:0] stall_vec_t;

  // Front-end command opcodes as seen by the profiler
  typedef enum logic [1:0] {
    e_cmd_attaboy    = 2'd0,
    e_cmd_redirect   = 2'd1,
    e_cmd_mispredict = 2'd2,
    e_cmd_other      = 2'd3
  } fe_cmd_op_e;

endpackage

// File: design/fe_stall_track.sv
/* Fetch stage 1 and stage 2 stall reason registers */
module fe_stall_track
  (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       fe_cmd_v_i,
    input  stall_prof_pkg::fe_cmd_op_e fe_cmd_op_i,
    input  logic                       br_ovr_i,
    input  logic                       ic_miss_i,
    input  logic                       icache_tl_we_i,
    input  logic                       icache_tv_we_i,
    output stall_prof_pkg::stall_vec_t fe_stall_o
  );

  import stall_prof_pkg::*;

  stall_vec_t cmd_vec;
  stall_vec_t s1_r;
  stall_vec_t s1_n;
  stall_vec_t s2_r;
  stall_vec_t s2_n;

  // Reasons raised by an accepted command
  always_comb
  begin
    cmd_vec = '0;
    if (fe_cmd_v_i)
    begin
      case (fe_cmd_op_i)
        e_cmd_mispredict: cmd_vec[e_mispredict] = 1'b1;
        e_cmd_redirect,
        e_cmd_other:      cmd_vec[e_fe_cmd] = 1'b1;
        // attaboy only confirms a prediction
        default:          cmd_vec = '0;
      endcase
    end
  end

  always_comb
  begin
    // Tag lookup write starts a fresh fetch in stage 1
    s1_n = icache_tl_we_i ? '0 : s1_r;
    s1_n = s1_n | cmd_vec;
    s1_n[e_br_ovr] = s1_n[e_br_ovr] | br_ovr_i;

    // Stage 2 advances on tag verify, holds otherwise
    s2_n = icache_tv_we_i ? s1_r : s2_r;
    s2_n = s2_n | cmd_vec;
    s2_n[e_ic_miss] = s2_n[e_ic_miss] | ic_miss_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      s1_r <= '0;
      s2_r <= '0;
    end
    else
    begin
      s1_r <= s1_n;
      s2_r <= s2_n;
    end
  end

  assign fe_stall_o = s2_r;

  // One command names at most one fetch reason
  cmd_one_reason_a : assert property (@(posedge clk_i) disable iff (reset_i)
    fe_cmd_v_i |-> $onehot0({cmd_vec[e_mispredict], cmd_vec[e_fe_cmd]}));

endmodule

// File: design/isd_hazard_classify.sv
/* Issue stage hazard reasons and mispredict suppression flag */
module isd_hazard_classify
  (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       mispredict_i,
    input  logic                       suppress_iss_i,
    input  logic                       clear_iss_i,
    input  logic                       data_haz_i,
    input  logic                       control_haz_i,
    input  logic                       struct_haz_i,
    input  logic                       long_haz_i,
    input  logic                       mem_haz_i,
    output stall_prof_pkg::stall_vec_t isd_stall_o
  );

  import stall_prof_pkg::*;

  logic       mispredict_r;
  stall_vec_t isd_vec;

  // Pending mispredict, held until the issue queue is cleared
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      mispredict_r <= 1'b0;
    end
    else if (mispredict_i)
    begin
      mispredict_r <= 1'b1;
    end
    else if (clear_iss_i)
    begin
      mispredict_r <= 1'b0;
    end
  end

  always_comb
  begin
    isd_vec = '0;

    // Suppressed issue is charged to the redirect behind it
    isd_vec[e_mispredict]   = mispredict_i | (suppress_iss_i & mispredict_r);
    isd_vec[e_fe_cmd_fence] = suppress_iss_i & ~mispredict_r;

    isd_vec[e_control_haz]  = control_haz_i;
    isd_vec[e_data_haz]     = data_haz_i;
    isd_vec[e_struct_haz]   = struct_haz_i;
    isd_vec[e_long_haz]     = long_haz_i;

    // Memory pipe busy means an outstanding D$ miss
    isd_vec[e_dc_miss]      = mem_haz_i;
  end

  assign isd_stall_o = isd_vec;

  // Set and clear of the flag come from different pipeline events
  flag_set_clr_a : assert property (@(posedge clk_i) disable iff (reset_i)
    mispredict_i |-> !clear_iss_i);

endmodule

// File: design/stall_attrib.sv
/* Issue and execute stage reason pipeline with commit events,
   priority encode and registered stall reason */
module stall_attrib
  (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  stall_prof_pkg::stall_vec_t    fe_stall_i,
    input  stall_prof_pkg::stall_vec_t    isd_stall_i,
    input  logic                          fe_queue_empty_i,
    input  logic                          instret_i,
    input  logic                          freeze_i,
    input  logic                          exception_i,
    input  logic                          itlb_miss_i,
    input  logic                          dtlb_miss_i,
    input  logic                          dc_miss_i,
    input  logic                          commit_ic_miss_i,
    input  logic                          retire_mispredict_i,
    output logic                          stall_v_o,
    output stall_prof_pkg::stall_reason_e stall_reason_o
  );

  import stall_prof_pkg::*;

  stall_vec_t    commit_vec;
  stall_vec_t    fe_sel;
  stall_vec_t    s3_r;
  stall_vec_t    s4_r;
  stall_vec_t    s5_r;
  stall_vec_t    s3_n;
  stall_vec_t    s4_n;
  stall_vec_t    s5_n;
  stall_vec_t    enc_vec;
  stall_reason_e enc_reason;
  logic          stall_v_r;
  stall_reason_e stall_reason_r;

  // Events reported at commit, charged to every execute stage
  always_comb
  begin
    commit_vec = '0;
    commit_vec[e_mispredict] = retire_mispredict_i;
    commit_vec[e_exception]  = exception_i;
    commit_vec[e_itlb_miss]  = itlb_miss_i;
    commit_vec[e_dtlb_miss]  = dtlb_miss_i;
    commit_vec[e_dc_miss]    = dc_miss_i;
    commit_vec[e_ic_miss]    = commit_ic_miss_i;
  end

  always_comb
  begin
    // Fetch reasons only matter when issue has nothing to take
    fe_sel = fe_queue_empty_i ? fe_stall_i : '0;

    s3_n = fe_sel | isd_stall_i | commit_vec;
    s4_n = s3_r | commit_vec;
    s5_n = s4_r | commit_vec;

    enc_vec = s5_r | commit_vec;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      s3_r <= '0;
      s4_r <= '0;
      s5_r <= '0;
    end
    else
    begin
      s3_r <= s3_n;
      s4_r <= s4_n;
      s5_r <= s5_n;
    end
  end

  // Lowest set bit wins, nothing set maps to unknown
  always_comb
  begin
    enc_reason = e_unknown;
    for (int i = num_reasons_c - 1; i >= 0; i--)
    begin
      if (enc_vec[i])
      begin
        enc_reason = stall_reason_e'(i);
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      stall_v_r <= 1'b0;
    end
    else
    begin
      stall_v_r <= ~instret_i & ~freeze_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    stall_reason_r <= enc_reason;
  end

  assign stall_v_o      = stall_v_r;
  assign stall_reason_o = stall_reason_r;

  // Histogram indexes by this value
  reason_range_a : assert property (@(posedge clk_i) disable iff (reset_i)
    stall_reason_o inside {[e_mispredict:e_unknown]});

endmodule

// File: design/stall_hist.sv
/* Saturating lost-cycle counters per stall reason with read select */
module stall_hist
  #(
    parameter int cnt_width_p = 16
  )
  (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          stall_v_i,
    input  stall_prof_pkg::stall_reason_e stall_reason_i,
    input  stall_prof_pkg::stall_reason_e count_sel_i,
    output logic [cnt_width_p-1:0]        count_o
  );

  import stall_prof_pkg::*;

  // One counter per encoding, e_unknown included
  logic [cnt_width_p-1:0] cnt_r [0:num_reasons_c];

  for (genvar i = 0; i <= num_reasons_c; i++)
  begin : g_cnt
    logic inc;

    // Hold at all ones once full
    assign inc = stall_v_i && (stall_reason_i == stall_reason_e'(i)) && (cnt_r[i] != '1);

    always_ff @(posedge clk_i)
    begin
      if (reset_i)
      begin
        cnt_r[i] <= '0;
      end
      else if (inc)
      begin
        cnt_r[i] <= cnt_r[i] + 1'b1;
      end
    end

    cnt_monotonic_a : assert property (@(posedge clk_i) disable iff (reset_i)
      cnt_r[i] >= $past(cnt_r[i]));
  end

  assign count_o = cnt_r[count_sel_i];

endmodule

// File: design/core_stall_profiler.sv
/* Stall profiler top: front-end tracker, issue classifier,
   attribution pipeline and histogram */
module core_stall_profiler
  #(
    parameter int cnt_width_p = 16
  )
  (
    input  logic                          clk_i,
    input  logic                          reset_i,
    // Front end
    input  logic                          fe_cmd_v_i,
    input  stall_prof_pkg::fe_cmd_op_e    fe_cmd_op_i,
    input  logic                          br_ovr_i,
    input  logic                          ic_miss_i,
    input  logic                          icache_tl_we_i,
    input  logic                          icache_tv_we_i,
    // Issue
    input  logic                          fe_queue_empty_i,
    input  logic                          mispredict_i,
    input  logic                          suppress_iss_i,
    input  logic                          clear_iss_i,
    input  logic                          data_haz_i,
    input  logic                          control_haz_i,
    input  logic                          struct_haz_i,
    input  logic                          long_haz_i,
    input  logic                          mem_haz_i,
    // Commit
    input  logic                          instret_i,
    input  logic                          exception_i,
    input  logic                          itlb_miss_i,
    input  logic                          dtlb_miss_i,
    input  logic                          dc_miss_i,
    input  logic                          commit_ic_miss_i,
    input  logic                          retire_mispredict_i,
    input  logic                          freeze_i,
    input  stall_prof_pkg::stall_reason_e count_sel_i,
    output logic                          stall_v_o,
    output stall_prof_pkg::stall_reason_e stall_reason_o,
    output logic [cnt_width_p-1:0]        count_o
  );

  import stall_prof_pkg::*;

  stall_vec_t fe_stall;
  stall_vec_t isd_stall;

  fe_stall_track u_fe_stall_track
    (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .fe_cmd_v_i     (fe_cmd_v_i),
      .fe_cmd_op_i    (fe_cmd_op_i),
      .br_ovr_i       (br_ovr_i),
      .ic_miss_i      (ic_miss_i),
      .icache_tl_we_i (icache_tl_we_i),
      .icache_tv_we_i (icache_tv_we_i),
      .fe_stall_o     (fe_stall)
    );

  isd_hazard_classify u_isd_hazard_classify
    (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .mispredict_i   (mispredict_i),
      .suppress_iss_i (suppress_iss_i),
      .clear_iss_i    (clear_iss_i),
      .data_haz_i     (data_haz_i),
      .control_haz_i  (control_haz_i),
      .struct_haz_i   (struct_haz_i),
      .long_haz_i     (long_haz_i),
      .mem_haz_i      (mem_haz_i),
      .isd_stall_o    (isd_stall)
    );

  stall_attrib u_stall_attrib
    (
      .clk_i               (clk_i),
      .reset_i             (reset_i),
      .fe_stall_i          (fe_stall),
      .isd_stall_i         (isd_stall),
      .fe_queue_empty_i    (fe_queue_empty_i),
      .instret_i           (instret_i),
      .freeze_i            (freeze_i),
      .exception_i         (exception_i),
      .itlb_miss_i         (itlb_miss_i),
      .dtlb_miss_i         (dtlb_miss_i),
      .dc_miss_i           (dc_miss_i),
      .commit_ic_miss_i    (commit_ic_miss_i),
      .retire_mispredict_i (retire_mispredict_i),
      .stall_v_o           (stall_v_o),
      .stall_reason_o      (stall_reason_o)
    );

  // Histogram sees the same registered reason as the outputs
  stall_hist #(
      .cnt_width_p (cnt_width_p)
    ) u_stall_hist
    (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .stall_v_i      (stall_v_o),
      .stall_reason_i (stall_reason_o),
      .count_sel_i    (count_sel_i),
      .count_o        (count_o)
    );

endmodule

// File: verification/tb_clock_gen.sv
/* Testbench clock and synchronous reset source */
module tb_clock_gen
  #(
    parameter int reset_cycles_p = 5
  )
  (
    output logic clk_o,
    output logic reset_o
  );

  timeunit 1ns;
  timeprecision 1ps;

  initial
  begin
    clk_o   = 1'b0;
    reset_o = 1'b1;
    forever #20 clk_o = ~clk_o;
  end

  initial
  begin
    repeat (reset_cycles_p) @(posedge clk_o);
    #2 reset_o = 1'b0;
  end

endmodule

// File: verification/core_stall_profiler_tb.sv
/* Profiler testbench with reference model, concurrent checks and
   phased random stimulus */
module core_stall_profiler_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import stall_prof_pkg::*;

  localparam int phase_cycles_c = 70;
  localparam int max_cycles_c   = 600;

  logic clk_i;
  logic reset_i;
  logic fe_cmd_v_i, br_ovr_i, ic_miss_i, icache_tl_we_i, icache_tv_we_i;
  fe_cmd_op_e fe_cmd_op_i;
  logic fe_queue_empty_i, mispredict_i, suppress_iss_i, clear_iss_i;
  logic data_haz_i, control_haz_i, struct_haz_i, long_haz_i, mem_haz_i;
  logic instret_i, exception_i, itlb_miss_i, dtlb_miss_i, dc_miss_i;
  logic commit_ic_miss_i, retire_mispredict_i, freeze_i;
  stall_reason_e count_sel_i;
  logic stall_v_o;
  stall_reason_e stall_reason_o;
  logic [15:0] count_o;

  int errors = 0;
  int cycles = 0;
  integer seed = 32'h9ef2d5b3;

  // Reference state built from the profiler rules
  stall_vec_t m_s1, m_s2, m_s3, m_s4, m_s5;
  stall_vec_t cmd_v, isd_v, com_v;
  logic m_flag;
  logic exp_v;
  stall_reason_e exp_reason;
  logic [15:0] exp_cnt [0:num_reasons_c];

  tb_clock_gen #(.reset_cycles_p(5)) u_clock_gen (.clk_o(clk_i), .reset_o(reset_i));

  core_stall_profiler #(.cnt_width_p(16)) DUT (.*);

  // First flagged reason in priority order
  function automatic stall_reason_e lowest_reason(stall_vec_t v);
    for (int i = 0; i < num_reasons_c; i++)
    begin
      if (v[i])
      begin
        return stall_reason_e'(i);
      end
    end
    return e_unknown;
  endfunction

  always_comb
  begin
    cmd_v = '0;
    if (fe_cmd_v_i && fe_cmd_op_i == e_cmd_mispredict)
      cmd_v[e_mispredict] = 1'b1;
    else if (fe_cmd_v_i && fe_cmd_op_i != e_cmd_attaboy)
      cmd_v[e_fe_cmd] = 1'b1;
    isd_v = '0;
    if (suppress_iss_i)
    begin
      if (m_flag)
        isd_v[e_mispredict] = 1'b1;
      else
        isd_v[e_fe_cmd_fence] = 1'b1;
    end
    if (mispredict_i)
      isd_v[e_mispredict] = 1'b1;
    isd_v[e_control_haz]  = control_haz_i;
    isd_v[e_data_haz]     = data_haz_i;
    isd_v[e_struct_haz]   = struct_haz_i;
    isd_v[e_long_haz]     = long_haz_i;
    isd_v[e_dc_miss]      = mem_haz_i;
    com_v = '0;
    com_v[e_mispredict] = retire_mispredict_i;
    com_v[e_exception]  = exception_i;
    com_v[e_itlb_miss]  = itlb_miss_i;
    com_v[e_dtlb_miss]  = dtlb_miss_i;
    com_v[e_dc_miss]    = dc_miss_i;
    com_v[e_ic_miss]    = commit_ic_miss_i;
  end

  always @(posedge clk_i)
  begin
    exp_reason <= lowest_reason(m_s5 | com_v);
    if (reset_i)
    begin
      {m_s1, m_s2, m_s3, m_s4, m_s5} <= '0;
      m_flag <= 1'b0;
      exp_v  <= 1'b0;
      for (int i = 0; i <= num_reasons_c; i++)
        exp_cnt[i] <= '0;
    end
    else
    begin
      m_s1 <= (icache_tl_we_i ? '0 : m_s1) | cmd_v | (stall_vec_t'(br_ovr_i) << e_br_ovr);
      m_s2 <= (icache_tv_we_i ? m_s1 : m_s2) | cmd_v | (stall_vec_t'(ic_miss_i) << e_ic_miss);
      m_s3 <= (fe_queue_empty_i ? m_s2 : '0) | isd_v | com_v;
      m_s4 <= m_s3 | com_v;
      m_s5 <= m_s4 | com_v;
      m_flag <= mispredict_i ? 1'b1 : (clear_iss_i ? 1'b0 : m_flag);
      exp_v <= ~instret_i & ~freeze_i;
      if (exp_v && exp_cnt[exp_reason] != '1)
        exp_cnt[exp_reason] <= exp_cnt[exp_reason] + 1'b1;
    end
  end

  reason_chk_a : assert property (@(posedge clk_i) disable iff (reset_i)
    stall_reason_o == exp_reason)
  else
  begin
    errors++;
    $display("mismatch at %0t: stall_reason_o expected %0d got %0d",
             $time, $sampled(exp_reason), $sampled(stall_reason_o));
  end

  valid_chk_a : assert property (@(posedge clk_i) disable iff (reset_i)
    stall_v_o == exp_v)
  else
  begin
    errors++;
    $display("mismatch at %0t: stall_v_o expected %0b got %0b",
             $time, $sampled(exp_v), $sampled(stall_v_o));
  end

  count_chk_a : assert property (@(posedge clk_i) disable iff (reset_i)
    count_o == exp_cnt[count_sel_i])
  else
  begin
    errors++;
    $display("mismatch at %0t: count_o[%0d] expected %0d got %0d", $time,
             $sampled(count_sel_i), $sampled(exp_cnt[count_sel_i]), $sampled(count_o));
  end

  // Phase 0 idle with retirement, 1 issue, 2 commit, 3 front end, 4 suppression, 5 mixed
  task automatic set_inputs(int phase, int n);
    logic [31:0] r;
    r = $random(seed);
    {fe_cmd_v_i, br_ovr_i, ic_miss_i, icache_tl_we_i, icache_tv_we_i} = '0;
    {fe_queue_empty_i, mispredict_i, suppress_iss_i, clear_iss_i} = '0;
    {data_haz_i, control_haz_i, struct_haz_i, long_haz_i, mem_haz_i} = '0;
    {exception_i, itlb_miss_i, dtlb_miss_i, dc_miss_i} = '0;
    {commit_ic_miss_i, retire_mispredict_i, freeze_i} = '0;
    instret_i   = (phase == 0);
    fe_cmd_op_i = fe_cmd_op_e'(r[1:0]);
    count_sel_i = stall_reason_e'((phase == 0) ? n % 14 : r[31:28] % 14);
    if (phase == 1 || phase == 5)
      {data_haz_i, control_haz_i, struct_haz_i, long_haz_i, mem_haz_i} = r[8:4] & r[13:9];
    if (phase == 2 || phase == 5)
    begin
      {exception_i, itlb_miss_i, dtlb_miss_i, dc_miss_i} = r[17:14] & r[21:18];
      {commit_ic_miss_i, retire_mispredict_i} = r[23:22] & r[25:24];
      instret_i = (r[27:26] == 2'b00);
    end
    if (phase == 3 || phase == 5)
    begin
      {fe_cmd_v_i, br_ovr_i, ic_miss_i} = r[4:2] & r[7:5];
      {icache_tl_we_i, icache_tv_we_i, fe_queue_empty_i} = r[10:8];
    end
    if (phase == 4 || phase == 5)
    begin
      mispredict_i   = (r[14:12] == 3'd0);
      clear_iss_i    = !mispredict_i && (r[17:15] == 3'd1);
      suppress_iss_i = r[18];
    end
    if (phase == 5)
      freeze_i = (r[20:19] == 2'b00);
  endtask

  always @(posedge clk_i)
  begin
    cycles++;
    if (cycles >= max_cycles_c)
    begin
      $display("Run stopped after %0d cycles without finishing the tests", cycles);
      $display("Errors found");
      $finish;
    end
  end

  initial
  begin
    set_inputs(0, 0);
    count_sel_i = e_mispredict;
    wait (reset_i == 1'b0);
    for (int ph = 0; ph <= 5; ph++)
    begin
      for (int n = 0; n < phase_cycles_c; n++)
      begin
        @(posedge clk_i);
        #2;
        set_inputs(ph, n);
      end
    end
    // Drain the pipeline with every counter read back
    for (int n = 0; n < 20; n++)
    begin
      @(posedge clk_i);
      #2;
      set_inputs(0, n);
    end
    @(posedge clk_i);
    #1;
    $display("Checks failed: %0d", errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// File: list.f
design/stall_prof_pkg.sv
design/fe_stall_track.sv
design/isd_hazard_classify.sv
design/stall_attrib.sv
design/stall_hist.sv
design/core_stall_profiler.sv
verification/tb_clock_gen.sv
verification/core_stall_profiler_tb.sv
